//--- source/mandel_cfg.svh
`ifndef MANDEL_CFG_SVH
`define MANDEL_CFG_SVH

// coordinate word, Q2.14.
`define MANDEL_WIDTH  16
`define MANDEL_FRAC   14

// index 255 is the last one reported.
`define MANDEL_ITERS  256
`define MANDEL_ITER_W 8

`endif

//--- source/mandel_pkg.sv
`default_nettype none
`include "mandel_cfg.svh"

package mandel_pkg;

   // signed q2.14 coordinate.
   typedef logic signed [`MANDEL_WIDTH-1:0] mandel_fix_t;

   typedef logic [`MANDEL_ITER_W-1:0] mandel_iter_t;

   typedef struct packed {
      mandel_iter_t iter;     // escape index or max.
      logic         bounded;  // never escaped.
   } mandel_res_t;

endpackage

`default_nettype wire

//--- source/mandel_if.sv
`timescale 1ns/100ps
`default_nettype none

interface mandel_job_if;
   logic                    start;  // one cycle, only while idle.
   mandel_pkg::mandel_fix_t c_re;
   mandel_pkg::mandel_fix_t c_im;
   logic                    busy;

   modport src (
      output start,
      output c_re,
      output c_im,
      input  busy
   );

   modport dst (
      input  start,
      input  c_re,
      input  c_im,
      output busy
   );
endinterface

interface mandel_res_if;
   logic                    valid;  // one cycle strobe.
   mandel_pkg::mandel_res_t res;

   modport src (
      output valid,
      output res
   );

   // sink samples only, no stall path.
   modport dst (
      input  valid,
      input  res
   );
endinterface

`default_nettype wire

//--- source/mandel_decode.sv
`timescale 1ns/100ps
`default_nettype none
`include "mandel_cfg.svh"

module mandel_decode (
   input  logic                    i_clk,
   input  logic                    i_nrst,
   input  logic                    i_req,
   input  mandel_pkg::mandel_fix_t i_c_re,
   input  mandel_pkg::mandel_fix_t i_c_im,
   output logic                    o_busy,
   mandel_job_if.src               job,
   mandel_res_if.src               sc,
   input  logic                    i_fin
);
   localparam int W = `MANDEL_WIDTH;
   localparam int F = `MANDEL_FRAC;
   localparam logic signed [W:0]     ONE      = 1 <<< F;
   localparam logic signed [2*W+2:0] BULB_LIM = 1 <<< (2*F - 4);  // 1/16 in q4.28.

   logic                    busy;
   logic                    pend;
   mandel_pkg::mandel_fix_t c_re_q;
   mandel_pkg::mandel_fix_t c_im_q;
   logic signed [W:0]       re_p1;
   logic signed [2*W+1:0]   re_p1_sq;
   logic signed [2*W-1:0]   im_sq;
   logic signed [2*W+2:0]   bulb_sum;
   logic                    in_bulb;
   logic                    accept;
   logic                    go_sc;
   logic                    go_job;

   assign accept = i_req & ~busy;  // drop while busy.
   assign o_busy = busy;

   // period-2 bulb, (re+1)^2 + im^2 < 1/16.
   assign re_p1    = $signed({c_re_q[W-1], c_re_q}) + ONE;
   assign re_p1_sq = re_p1 * re_p1;
   assign im_sq    = c_im_q * c_im_q;
   assign bulb_sum = re_p1_sq + im_sq;
   assign in_bulb  = bulb_sum < BULB_LIM;

   assign go_sc  = pend & in_bulb;
   assign go_job = pend & ~in_bulb & ~job.busy;

   assign sc.res.iter    = mandel_pkg::mandel_iter_t'(`MANDEL_ITERS - 1);
   assign sc.res.bounded = 1'b1;
   assign job.c_re       = c_re_q;
   assign job.c_im       = c_im_q;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         busy      <= 1'b0;
         pend      <= 1'b0;
         sc.valid  <= 1'b0;
         job.start <= 1'b0;
      end else begin
         sc.valid  <= go_sc;
         job.start <= go_job;
         if (accept) begin
            busy <= 1'b1;
            pend <= 1'b1;
         end else begin
            if (i_fin)
               busy <= 1'b0;  // done pulse ends the job.
            if (go_sc | go_job)
               pend <= 1'b0;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (accept) begin
         c_re_q <= i_c_re;
         c_im_q <= i_c_im;
      end
   end

endmodule

`default_nettype wire

//--- source/mandel_iterate.sv
`timescale 1ns/100ps
`default_nettype none
`include "mandel_cfg.svh"

module mandel_iterate (
   input  logic      i_clk,
   input  logic      i_nrst,
   mandel_job_if.dst job,
   mandel_res_if.src res
);
   localparam int W = `MANDEL_WIDTH;
   localparam int F = `MANDEL_FRAC;
   localparam mandel_pkg::mandel_iter_t IDX_MAX = mandel_pkg::mandel_iter_t'(`MANDEL_ITERS - 1);
   localparam logic signed [2*W:0] ESC_LIM = 1 <<< (2*F + 2);  // 4.0 in q4.28.

   logic                      running;
   mandel_pkg::mandel_iter_t  idx;
   mandel_pkg::mandel_fix_t   re;
   mandel_pkg::mandel_fix_t   im;
   mandel_pkg::mandel_fix_t   c_re;
   mandel_pkg::mandel_fix_t   c_im;
   logic signed [2*W:0]       re_sq;
   logic signed [2*W:0]       im_sq;
   logic signed [2*W:0]       re_im2;
   logic signed [2*W:0]       mag;
   logic signed [2*W:0]       re_full;
   mandel_pkg::mandel_fix_t   re_nx;
   mandel_pkg::mandel_fix_t   im_nx;
   logic                      escape;
   logic                      last;
   logic                      fin;

   assign re_sq  = re * re;
   assign im_sq  = im * im;
   assign re_im2 = (re * im) <<< 1;
   assign mag    = re_sq + im_sq;
   assign escape = mag > ESC_LIM;
   assign last   = idx == IDX_MAX;
   assign fin    = running & (escape | last);

   // floor shift back to q2.14, then add c.
   assign re_full = re_sq - im_sq;
   assign re_nx   = mandel_pkg::mandel_fix_t'(re_full[F +: W]) + c_re;
   assign im_nx   = mandel_pkg::mandel_fix_t'(re_im2[F +: W]) + c_im;

   assign job.busy        = running;
   assign res.valid       = fin;
   assign res.res.iter    = idx;
   assign res.res.bounded = ~escape;  // last index without escape.

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         running <= 1'b0;
         idx     <= '0;
      end else if (job.start) begin
         running <= 1'b1;
         idx     <= mandel_pkg::mandel_iter_t'(1);  // z1 = c.
      end else if (running) begin
         if (fin)
            running <= 1'b0;
         else
            idx <= idx + 1'b1;
      end
   end

   always_ff @(posedge i_clk) begin
      if (job.start) begin
         re   <= job.c_re;
         im   <= job.c_im;
         c_re <= job.c_re;
         c_im <= job.c_im;
      end else if (running && !fin) begin
         re <= re_nx;
         im <= im_nx;
      end
   end

   // decode must hold off while a point is in flight.
   a_no_start_while_running : assert property (
      @(posedge i_clk) disable iff (!i_nrst) job.start |-> !running
   );

endmodule

`default_nettype wire

//--- source/mandel_result.sv
`timescale 1ns/100ps
`default_nettype none

module mandel_result (
   input  logic                     i_clk,
   input  logic                     i_nrst,
   mandel_res_if.dst                sc,
   mandel_res_if.dst                it,
   output logic                     o_done,
   output mandel_pkg::mandel_iter_t o_iter,
   output logic                     o_bounded
);
   mandel_pkg::mandel_res_t res_q;
   mandel_pkg::mandel_res_t res_sel;
   logic                    any_valid;

   assign any_valid = sc.valid | it.valid;
   assign res_sel   = sc.valid ? sc.res : it.res;  // only one source at a time.

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_done <= 1'b0;
         res_q  <= '0;
      end else begin
         o_done <= any_valid;
         if (any_valid)
            res_q <= res_sel;  // held until next result.
      end
   end

   assign o_iter    = res_q.iter;
   assign o_bounded = res_q.bounded;

   // shortcut and iterate paths are exclusive per request.
   a_one_source : assert property (
      @(posedge i_clk) disable iff (!i_nrst) !(sc.valid && it.valid)
   );

endmodule

`default_nettype wire

//--- source/mandel_top.sv
`timescale 1ns/100ps
`default_nettype none

module mandel_top (
   input  logic                     i_clk,
   input  logic                     i_nrst,
   input  logic                     i_req,
   input  mandel_pkg::mandel_fix_t  i_c_re,
   input  mandel_pkg::mandel_fix_t  i_c_im,
   output logic                     o_busy,
   output logic                     o_done,
   output mandel_pkg::mandel_iter_t o_iter,
   output logic                     o_bounded
);
   mandel_job_if job_if ();
   mandel_res_if sc_if ();  // bulb shortcut.
   mandel_res_if it_if ();

   mandel_decode u_decode (
      .i_clk  (i_clk),
      .i_nrst (i_nrst),
      .i_req  (i_req),
      .i_c_re (i_c_re),
      .i_c_im (i_c_im),
      .o_busy (o_busy),
      .job    (job_if.src),
      .sc     (sc_if.src),
      .i_fin  (o_done)  // done frees decode.
   );

   mandel_iterate u_iterate (
      .i_clk  (i_clk),
      .i_nrst (i_nrst),
      .job    (job_if.dst),
      .res    (it_if.src)
   );

   mandel_result u_result (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .sc        (sc_if.dst),
      .it        (it_if.dst),
      .o_done    (o_done),
      .o_iter    (o_iter),
      .o_bounded (o_bounded)
   );

endmodule

`default_nettype wire

//--- tb/mandel_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mandel_tb;
   localparam int          HALF_PERIOD  = 10;
   localparam int          DONE_TIMEOUT = 400;
   localparam int          HOLD_CYCLES  = 6;
   localparam string       TRACE_PATH   = "tb/mandel_trace.txt";
   localparam logic [15:0] DROP_RE      = 16'hC000;  // -1.0+0.75i, would escape at 3.
   localparam logic [15:0] DROP_IM      = 16'h3000;

   logic                     i_clk;
   logic                     i_nrst;
   logic                     i_req;
   mandel_pkg::mandel_fix_t  i_c_re;
   mandel_pkg::mandel_fix_t  i_c_im;
   logic                     o_busy;
   logic                     o_done;
   mandel_pkg::mandel_iter_t o_iter;
   logic                     o_bounded;

   integer seed;
   integer n_tests;
   integer n_failed;
   integer n_err;
   logic   aborted;

   mandel_top u_mandel_top (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_req     (i_req),
      .i_c_re    (i_c_re),
      .i_c_im    (i_c_im),
      .o_busy    (o_busy),
      .o_done    (o_done),
      .o_iter    (o_iter),
      .o_bounded (o_bounded)
   );

   initial begin
      i_clk = 1'b0;
      forever #HALF_PERIOD i_clk = ~i_clk;
   end

   task automatic report_mismatch(input string field, input integer got, input integer exp);
      $display("ERR %0t: %s is %0h, expected %0h", $time, field, got, exp);
      n_err = n_err + 1;
   endtask

   task automatic finish_test(input string name, input integer errs_before);
      n_tests = n_tests + 1;
      if (n_err == errs_before) begin
         $display("test %0d %s: ok", n_tests, name);
      end else begin
         n_failed = n_failed + 1;
         $display("test %0d %s: failed, %0d errors", n_tests, name, n_err - errs_before);
      end
   endtask

   task automatic check_reset_state();
      integer errs_before;
      errs_before = n_err;
      repeat (2) begin
         if (o_busy !== 1'b0)
            report_mismatch("o_busy", o_busy, 0);
         if (o_done !== 1'b0)
            report_mismatch("o_done", o_done, 0);
         if (o_iter !== 8'h00)
            report_mismatch("o_iter", o_iter, 0);
         if (o_bounded !== 1'b0)
            report_mismatch("o_bounded", o_bounded, 0);
         @(posedge i_clk);
         #2;
      end
      finish_test("reset state", errs_before);
   endtask

   // enters and leaves 2 ns after a rising edge.
   task automatic run_point(input integer mode, input logic [15:0] c_re, input logic [15:0] c_im,
                            input integer exp_iter, input integer exp_bnd);
      integer       errs_before;
      integer       cycles;
      integer       gap;
      logic         got_done;
      logic   [7:0] held_iter;
      logic         held_bnd;
      errs_before = n_err;
      i_req  = 1'b1;
      i_c_re = c_re;
      i_c_im = c_im;
      @(posedge i_clk);
      #2;
      cycles = 0;
      if (mode == 2) begin
         if (o_busy !== 1'b1) begin
            $display("o_busy was low when the second request was driven at %0t", $time);
            n_err = n_err + 1;
         end
         i_c_re = DROP_RE;  // req stays high for one more edge.
         i_c_im = DROP_IM;
         @(posedge i_clk);
         #2;
         cycles = 1;
      end
      i_req = 1'b0;
      got_done = 1'b0;
      while (!got_done && cycles < DONE_TIMEOUT) begin
         @(posedge i_clk);
         #1;
         cycles = cycles + 1;
         got_done = o_done;
         if (o_busy !== 1'b1)
            report_mismatch("o_busy while running", o_busy, 1);
      end
      if (!got_done) begin
         $display("timeout at %0t: the done strobe never came within %0d cycles",
                  $time, DONE_TIMEOUT);
         n_err = n_err + 1;
         aborted = 1'b1;
      end else begin
         if (o_iter !== exp_iter[7:0])
            report_mismatch("o_iter", o_iter, exp_iter);
         if (o_bounded !== exp_bnd[0])
            report_mismatch("o_bounded", o_bounded, exp_bnd);
         if (mode == 1 && cycles != 2)
            report_mismatch("shortcut latency", cycles, 2);
         held_iter = o_iter;
         held_bnd  = o_bounded;
         gap = {$random(seed)} % 4 + 1;
         if (mode == 2)
            gap = gap + HOLD_CYCLES;
         repeat (gap) begin
            @(posedge i_clk);
            #1;
            if (o_done !== 1'b0)
               report_mismatch("o_done after result", o_done, 0);
            if (o_busy !== 1'b0)
               report_mismatch("o_busy while idle", o_busy, 0);
            if (o_iter !== held_iter)
               report_mismatch("held o_iter", o_iter, held_iter);
            if (o_bounded !== held_bnd)
               report_mismatch("held o_bounded", o_bounded, held_bnd);
         end
         #1;
      end
      finish_test($sformatf("mode %0d c=(%h,%h)", mode, c_re, c_im), errs_before);
   endtask

   task automatic run_trace();
      integer fd;
      integer code;
      integer mode;
      integer c_re;
      integer c_im;
      integer exp_iter;
      integer exp_bnd;
      string  line;
      fd = $fopen(TRACE_PATH, "r");
      if (fd == 0) begin
         $display("could not open the trace file %s", TRACE_PATH);
         n_err = n_err + 1;
         aborted = 1'b1;
      end else begin
         while (!aborted && $fgets(line, fd) > 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
               code = $sscanf(line, "%h %h %h %h %h", mode, c_re, c_im, exp_iter, exp_bnd);
               if (code == 5) begin
                  run_point(mode, c_re[15:0], c_im[15:0], exp_iter, exp_bnd);
               end else begin
                  $display("a trace line could not be read: %s", line);
                  n_err = n_err + 1;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   initial begin
      seed     = 72;
      n_tests  = 0;
      n_failed = 0;
      n_err    = 0;
      aborted  = 1'b0;
      i_nrst   = 1'b0;
      i_req    = 1'b0;
      i_c_re   = '0;
      i_c_im   = '0;
      repeat (3) @(posedge i_clk);
      #2;
      i_nrst = 1'b1;
      check_reset_state();
      run_trace();
      $display("%0d tests, %0d passed, %0d failed, %0d errors",
               n_tests, n_tests - n_failed, n_failed, n_err);
      if (n_err == 0 && !aborted) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
+incdir+source
source/mandel_pkg.sv
source/mandel_if.sv
source/mandel_decode.sv
source/mandel_iterate.sv
source/mandel_result.sv
source/mandel_top.sv
tb/mandel_tb.sv

//--- Makefile
# Verilator flow for the Mandelbrot engine testbench.

LOG := sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal \
		-f tb.f --top-module mandel_tb \
		--Mdir obj_dir -o mandel_sim
	./obj_dir/mandel_sim | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module mandel_top

clean:
	rm -rf obj_dir $(LOG)

//--- tb/mandel_trace.txt
# mode c_re c_im iter bounded, all hex, c in signed q2.14.
# mode 0 iterates, mode 1 hits the bulb shortcut, mode 2 adds a request while busy.
0 6000 6000 01 0   # 1.5+1.5i
0 A000 A000 01 0   # -1.5-1.5i
0 6000 A000 01 0   # 1.5-1.5i
0 A000 4000 02 0   # -1.5+1.0i
0 C000 3000 03 0   # -1.0+0.75i
0 C000 D000 03 0   # -1.0-0.75i
0 8000 0666 01 0   # -2.0+0.1i, next to the tip
0 0000 0000 FF 1   # 0
0 F99A 0666 FF 1   # -0.1+0.1i
0 E000 2000 FF 1   # -0.5+0.5i
0 8000 0000 FF 1   # -2.0, fixed at the tip
0 8666 0000 FF 1   # -1.9
0 1000 0000 FF 1   # 0.25, cusp
1 C000 0000 FF 1   # -1.0
1 B99A 0333 FF 1   # -1.1+0.05i
1 C000 F99A FF 1   # -1.0-0.1i
1 B333 0000 FF 1   # -1.2
2 6000 6000 01 0   # escape, second request dropped
2 0000 0000 FF 1   # long bounded run, second request dropped
2 C000 0000 FF 1   # bulb, second request dropped
2 A000 4000 02 0   # escape at 2, second request dropped
